/* udp_loopback_pkg.sv */
// Shared types and constants for the UDP echo engine.
// Each RTL module imports this package in its body and uses scoped
// names for its port types.
// Input header is 12 bytes, most significant byte first:
// source IP, source port, destination port, length, checksum.

package udp_loopback_pkg;

    // Stream and header field types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Header layout
    localparam int HDR_BYTES = 12;

    typedef logic [3:0] hdr_cnt_t;

    // Byte offsets of each field; the IP address starts at offset 0
    localparam hdr_cnt_t SRC_PORT_OFS = 4'd4;
    localparam hdr_cnt_t DST_PORT_OFS = 4'd6;
    localparam hdr_cnt_t LEN_OFS      = 4'd8;
    localparam hdr_cnt_t CSUM_OFS     = 4'd10;

    // Packets to this port get echoed
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Payload FIFO
    localparam int FIFO_DEPTH = 16;

    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_addr_t;
    typedef logic [$clog2(FIFO_DEPTH):0]   fifo_cnt_t;

    // Per-packet decision in the control block
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DISCARD
    } ctrl_state_t;

endpackage

/* udp_hdr_parser.sv */
// Splits the input byte stream into a parsed header and a payload stream.
// The 12 header bytes are shifted into field registers, which are held
// with hdr_valid until hdr_ready. The payload then passes straight
// through to the pl_* stream until the last byte.

`timescale 1ns/1ps

module udp_hdr_parser (
    input  logic                        clk,
    input  logic                        rst,
    input  udp_loopback_pkg::byte_t     in_data,
    input  logic                        in_valid,
    input  logic                        in_last,
    input  logic                        in_user,
    output logic                        in_ready,
    output logic                        hdr_valid,
    input  logic                        hdr_ready,
    output udp_loopback_pkg::ip_addr_t  hdr_src_ip,
    output udp_loopback_pkg::udp_port_t hdr_src_port,
    output udp_loopback_pkg::udp_port_t hdr_dst_port,
    output udp_loopback_pkg::udp_len_t  hdr_length,
    output udp_loopback_pkg::byte_t     pl_data,
    output logic                        pl_valid,
    output logic                        pl_last,
    output logic                        pl_user,
    input  logic                        pl_ready
);
    import udp_loopback_pkg::*;

    hdr_cnt_t hdr_cnt;
    logic     payload_phase;
    logic     ready_en;
    logic     in_fire;
    logic     hdr_fire;

    // Header bytes are blocked while a parsed header waits downstream
    assign in_ready = ready_en && (payload_phase ? pl_ready : !hdr_valid);
    assign in_fire  = in_valid && in_ready;
    assign hdr_fire = in_fire && !payload_phase;

    // Payload pass-through
    assign pl_data  = in_data;
    assign pl_valid = payload_phase && in_valid;
    assign pl_last  = in_last;
    assign pl_user  = in_user;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en      <= 1'b0;
            hdr_cnt       <= '0;
            hdr_valid     <= 1'b0;
            payload_phase <= 1'b0;
        end else begin
            // Holds in_ready low for one cycle after reset
            ready_en <= 1'b1;

            if (hdr_fire) begin
                if (hdr_cnt == hdr_cnt_t'(HDR_BYTES - 1)) begin
                    hdr_cnt   <= '0;
                    hdr_valid <= 1'b1;
                end else begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                end
            end

            if (hdr_valid && hdr_ready) begin
                hdr_valid     <= 1'b0;
                payload_phase <= 1'b1;
            end

            // Back to header collection after the last payload byte
            if (payload_phase && in_fire && in_last) begin
                payload_phase <= 1'b0;
            end
        end
    end

    // Field registers, MSB first; checksum bytes are dropped
    always_ff @(posedge clk) begin
        if (hdr_fire) begin
            if (hdr_cnt < SRC_PORT_OFS) begin
                hdr_src_ip <= {hdr_src_ip[23:0], in_data};
            end else if (hdr_cnt < DST_PORT_OFS) begin
                hdr_src_port <= {hdr_src_port[7:0], in_data};
            end else if (hdr_cnt < LEN_OFS) begin
                hdr_dst_port <= {hdr_dst_port[7:0], in_data};
            end else if (hdr_cnt < CSUM_OFS) begin
                hdr_length <= {hdr_length[7:0], in_data};
            end
        end
    end

endmodule

/* loopback_ctrl.sv */
// Per-packet forward or discard decision.
// The destination port is compared with the echo port once, when the
// parsed header is taken. Matching packets hand the header to the
// frame transmitter and route the payload into the FIFO; other packets
// are drained and dropped.

`timescale 1ns/1ps

module loopback_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        hdr_valid,
    output logic                        hdr_ready,
    input  udp_loopback_pkg::udp_port_t hdr_dst_port,
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    input  udp_loopback_pkg::byte_t     pl_data,
    input  logic                        pl_valid,
    input  logic                        pl_last,
    input  logic                        pl_user,
    output logic                        pl_ready,
    output udp_loopback_pkg::byte_t     wr_data,
    output logic                        wr_valid,
    output logic                        wr_last,
    output logic                        wr_user,
    input  logic                        wr_ready
);
    import udp_loopback_pkg::*;

    ctrl_state_t state;
    logic        match;
    logic        hdr_fire;
    logic        pl_fire;

    assign match = hdr_dst_port == ECHO_PORT;

    // Header handshake, only taken in IDLE
    assign tx_hdr_valid = (state == IDLE) && hdr_valid && match;
    assign hdr_ready    = (state == IDLE) && hdr_valid && (match ? tx_hdr_ready : 1'b1);
    assign hdr_fire     = hdr_valid && hdr_ready;

    // Payload gating
    assign wr_data  = pl_data;
    assign wr_last  = pl_last;
    assign wr_user  = pl_user;
    assign wr_valid = (state == FORWARD) && pl_valid;

    always_comb begin
        case (state)
            FORWARD: pl_ready = wr_ready;
            // Dropped packets still drain
            DISCARD: pl_ready = 1'b1;
            default: pl_ready = 1'b0;
        endcase
    end

    assign pl_fire = pl_valid && pl_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (hdr_fire) begin
                        state <= match ? FORWARD : DISCARD;
                    end
                end
                FORWARD, DISCARD: begin
                    if (pl_fire && pl_last) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* payload_fifo.sv */
// First-word-fall-through byte FIFO for the echoed payload.
// Each entry holds the data byte with its last and user flags.
// A written byte shows on rd_valid in the following cycle; wr_ready
// drops when all entries are in use.

`timescale 1ns/1ps

module payload_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_loopback_pkg::byte_t wr_data,
    input  logic                    wr_valid,
    input  logic                    wr_last,
    input  logic                    wr_user,
    output logic                    wr_ready,
    output udp_loopback_pkg::byte_t rd_data,
    output logic                    rd_valid,
    output logic                    rd_last,
    output logic                    rd_user,
    input  logic                    rd_ready
);
    import udp_loopback_pkg::*;

    // Entry is {user, last, data}
    logic [$bits(byte_t)+1:0] mem [FIFO_DEPTH];
    logic [$bits(byte_t)+1:0] rd_word;
    fifo_addr_t               wr_ptr;
    fifo_addr_t               rd_ptr;
    fifo_cnt_t                count;
    logic                     wr_fire;
    logic                     rd_fire;

    assign wr_ready = count != fifo_cnt_t'(FIFO_DEPTH);
    assign rd_valid = count != '0;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    assign rd_word = mem[rd_ptr];
    assign {rd_user, rd_last, rd_data} = rd_word;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr_user, wr_last, wr_data};
        end
    end

    // Pointers wrap with the depth being a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* udp_frame_tx.sv */
// Builds the reply packet on the output stream.
// On a reply header transfer the header is latched with the IP taken
// from the received source, the ports swapped and a zero checksum.
// The 12 header bytes go out one by one, then the payload is streamed
// from the FIFO up to and including its last byte.

`timescale 1ns/1ps

module udp_frame_tx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tx_hdr_valid,
    output logic                        tx_hdr_ready,
    input  udp_loopback_pkg::ip_addr_t  hdr_src_ip,
    input  udp_loopback_pkg::udp_port_t hdr_src_port,
    input  udp_loopback_pkg::udp_port_t hdr_dst_port,
    input  udp_loopback_pkg::udp_len_t  hdr_length,
    input  udp_loopback_pkg::byte_t     rd_data,
    input  logic                        rd_valid,
    input  logic                        rd_last,
    input  logic                        rd_user,
    output logic                        rd_ready,
    output udp_loopback_pkg::byte_t     out_data,
    output logic                        out_valid,
    output logic                        out_last,
    output logic                        out_user,
    input  logic                        out_ready
);
    import udp_loopback_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_PAYLOAD
    } tx_state_t;

    tx_state_t state;
    hdr_cnt_t  idx;
    byte_t     reply_hdr [HDR_BYTES];
    logic      in_hdr;
    logic      in_payload;

    assign in_hdr     = state == TX_HDR;
    assign in_payload = state == TX_PAYLOAD;

    assign tx_hdr_ready = state == TX_IDLE;

    // Header bytes first, then the FIFO stream
    assign out_valid = in_hdr || (in_payload && rd_valid);
    assign out_data  = in_hdr ? reply_hdr[idx] : rd_data;
    assign out_last  = in_payload && rd_last;
    assign out_user  = in_payload && rd_user;
    assign rd_ready  = in_payload && out_ready;

    // Reply header, ports swapped and checksum zero
    always_ff @(posedge clk) begin
        if (tx_hdr_valid && tx_hdr_ready) begin
            reply_hdr[0]  <= hdr_src_ip[31:24];
            reply_hdr[1]  <= hdr_src_ip[23:16];
            reply_hdr[2]  <= hdr_src_ip[15:8];
            reply_hdr[3]  <= hdr_src_ip[7:0];
            reply_hdr[4]  <= hdr_dst_port[15:8];
            reply_hdr[5]  <= hdr_dst_port[7:0];
            reply_hdr[6]  <= hdr_src_port[15:8];
            reply_hdr[7]  <= hdr_src_port[7:0];
            reply_hdr[8]  <= hdr_length[15:8];
            reply_hdr[9]  <= hdr_length[7:0];
            reply_hdr[10] <= 8'h00;
            reply_hdr[11] <= 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_hdr_valid) begin
                        state <= TX_HDR;
                        idx   <= '0;
                    end
                end
                TX_HDR: begin
                    if (out_ready) begin
                        if (idx == hdr_cnt_t'(HDR_BYTES - 1)) begin
                            state <= TX_PAYLOAD;
                            idx   <= '0;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                TX_PAYLOAD: begin
                    if (rd_valid && out_ready && rd_last) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* udp_loopback_core.sv */
// Top level of the UDP echo engine.
// Chains the header parser, the forward/discard control, the payload
// FIFO and the reply transmitter between the input and output streams.

`timescale 1ns/1ps

module udp_loopback_core (
    input  logic                    clk,
    input  logic                    rst,
    input  udp_loopback_pkg::byte_t in_data,
    input  logic                    in_valid,
    input  logic                    in_last,
    input  logic                    in_user,
    output logic                    in_ready,
    output udp_loopback_pkg::byte_t out_data,
    output logic                    out_valid,
    output logic                    out_last,
    output logic                    out_user,
    input  logic                    out_ready
);
    import udp_loopback_pkg::*;

    // Parsed header
    logic      hdr_valid;
    logic      hdr_ready;
    ip_addr_t  hdr_src_ip;
    udp_port_t hdr_src_port;
    udp_port_t hdr_dst_port;
    udp_len_t  hdr_length;

    // Parser payload
    byte_t pl_data;
    logic  pl_valid;
    logic  pl_last;
    logic  pl_user;
    logic  pl_ready;

    // Reply header handshake
    logic tx_hdr_valid;
    logic tx_hdr_ready;

    // FIFO write and read sides
    byte_t wr_data;
    logic  wr_valid;
    logic  wr_last;
    logic  wr_user;
    logic  wr_ready;
    byte_t rd_data;
    logic  rd_valid;
    logic  rd_last;
    logic  rd_user;
    logic  rd_ready;

    udp_hdr_parser i_udp_hdr_parser (
        .clk, .rst,
        .in_data, .in_valid, .in_last, .in_user, .in_ready,
        .hdr_valid, .hdr_ready,
        .hdr_src_ip, .hdr_src_port, .hdr_dst_port, .hdr_length,
        .pl_data, .pl_valid, .pl_last, .pl_user, .pl_ready
    );

    loopback_ctrl i_loopback_ctrl (
        .clk, .rst,
        .hdr_valid, .hdr_ready, .hdr_dst_port,
        .tx_hdr_valid, .tx_hdr_ready,
        .pl_data, .pl_valid, .pl_last, .pl_user, .pl_ready,
        .wr_data, .wr_valid, .wr_last, .wr_user, .wr_ready
    );

    payload_fifo i_payload_fifo (
        .clk, .rst,
        .wr_data, .wr_valid, .wr_last, .wr_user, .wr_ready,
        .rd_data, .rd_valid, .rd_last, .rd_user, .rd_ready
    );

    // Header fields stay stable in the parser until hdr_ready
    udp_frame_tx i_udp_frame_tx (
        .clk, .rst,
        .tx_hdr_valid, .tx_hdr_ready,
        .hdr_src_ip, .hdr_src_port, .hdr_dst_port, .hdr_length,
        .rd_data, .rd_valid, .rd_last, .rd_user, .rd_ready,
        .out_data, .out_valid, .out_last, .out_user, .out_ready
    );

endmodule

/* tb_udp_loopback.sv */
// Self-checking testbench for the UDP echo engine.
// Random packets come from an LFSR. About half go to the echo port, and
// the last eight are all echoed and sent back to back. Expected reply
// bytes are queued as each packet is sent. Assertions on the output
// compare every transfer and check that a stalled byte is held.

`timescale 1ns/1ps

module tb_udp_loopback;
    import udp_loopback_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_PKTS     = 40;
    localparam int          BURST_START  = 32;
    localparam int          TIMEOUT_NS   = NUM_PKTS * 40 * 4 * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED    = 32'h0685_0f6f;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic  clk;
    logic  rst;
    byte_t in_data;
    logic  in_valid;
    logic  in_last;
    logic  in_user;
    logic  in_ready;
    byte_t out_data;
    logic  out_valid;
    logic  out_last;
    logic  out_user;
    logic  out_ready;

    // Expected output words, {user, last, data}
    logic [9:0]  exp_q [$];
    logic [31:0] lfsr_state = LFSR_SEED;
    int          echoed = 0;
    logic        stall_pending = 1'b0;
    logic        rst_d = 1'b0;
    byte_t       held_data;
    logic        held_last;
    logic        held_user;

    udp_loopback_core i_udp_loopback_core (
        .clk, .rst,
        .in_data, .in_valid, .in_last, .in_user, .in_ready,
        .out_data, .out_valid, .out_last, .out_user, .out_ready
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < n; i++) begin
            result = {result[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return result;
    endfunction

    task automatic value_error(input string name, input logic [7:0] exp, input logic [7:0] act);
        $display("Error at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
        $display("Test failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic fail_now(input string what);
        $display("At %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    task automatic push_expected(input byte_t d, input logic last, input logic user);
        exp_q.push_back({user, last, d});
    endtask

    // Holds the byte until in_ready is seen at a rising edge
    task automatic send_byte(input byte_t d, input logic last, input logic user);
        in_data  = d;
        in_last  = last;
        in_user  = user;
        in_valid = 1'b1;
        do @(posedge clk); while (!in_ready);
        #2;
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_user  = 1'b0;
    endtask

    task automatic send_packet(input bit force_match, input bit no_gaps);
        byte_t     pkt [$];
        ip_addr_t  ip;
        udp_port_t sport;
        udp_port_t dport;
        udp_len_t  len;
        int        plen;
        logic      user_bit;
        bit        matching;
        pkt.delete();
        plen     = int'(rand_bits(5) % 20) + 1;
        ip       = rand_bits(32);
        sport    = udp_port_t'(rand_bits(16));
        matching = force_match || rand_bits(1) == 1;
        if (matching) begin
            dport = ECHO_PORT;
        end else begin
            do dport = udp_port_t'(rand_bits(16)); while (dport == ECHO_PORT);
        end
        user_bit = rand_bits(3) == 0;
        len      = udp_len_t'(8 + plen);
        pkt = {ip[31:24], ip[23:16], ip[15:8], ip[7:0], sport[15:8], sport[7:0],
               dport[15:8], dport[7:0], len[15:8], len[7:0]};
        // Checksum on input is random, the reply carries zero
        pkt.push_back(byte_t'(rand_bits(8)));
        pkt.push_back(byte_t'(rand_bits(8)));
        for (int i = 0; i < plen; i++) begin
            pkt.push_back(byte_t'(rand_bits(8)));
        end
        if (matching) begin
            echoed++;
            for (int i = 0; i < 4; i++) begin
                push_expected(pkt[i], 1'b0, 1'b0);
            end
            push_expected(dport[15:8], 1'b0, 1'b0);
            push_expected(dport[7:0], 1'b0, 1'b0);
            push_expected(sport[15:8], 1'b0, 1'b0);
            push_expected(sport[7:0], 1'b0, 1'b0);
            push_expected(len[15:8], 1'b0, 1'b0);
            push_expected(len[7:0], 1'b0, 1'b0);
            push_expected(8'h00, 1'b0, 1'b0);
            push_expected(8'h00, 1'b0, 1'b0);
            for (int i = HDR_BYTES; i < pkt.size(); i++) begin
                push_expected(pkt[i], i == pkt.size() - 1, (i == pkt.size() - 1) && user_bit);
            end
        end
        for (int i = 0; i < pkt.size(); i++) begin
            if (!no_gaps && rand_bits(2) == 0) begin
                repeat (int'(rand_bits(2)) + 1) @(posedge clk);
                #2;
            end
            send_byte(pkt[i], i == pkt.size() - 1, (i == pkt.size() - 1) && user_bit);
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst       = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_user   = 1'b0;
        out_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < NUM_PKTS; i++) begin
            send_packet(i >= BURST_START, i >= BURST_START);
        end
        while (exp_q.size() != 0) @(posedge clk);
        // Idle tail, any stray output byte trips the monitor
        repeat (50) @(posedge clk);
        $display("%0d packets sent, %0d echoed", NUM_PKTS, echoed);
        if (exp_q.size() == 0 && !out_valid) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "reply stream incomplete");
        end
    end

    // Output stalls, some longer than the FIFO depth
    initial begin
        int   stall_left;
        logic next_ready;
        stall_left = 0;
        wait (rst == 1'b0);
        forever begin
            @(posedge clk);
            // Stall draws sit 1 ns ahead of the packet draws in each cycle
            #1;
            if (stall_left != 0) begin
                next_ready = 1'b0;
                stall_left--;
            end else if (rand_bits(4) == 0) begin
                next_ready = 1'b0;
                stall_left = int'(rand_bits(5)) + 4;
            end else begin
                next_ready = 1'b1;
            end
            #1;
            out_ready = next_ready;
        end
    end

    // Output monitor
    always @(posedge clk) begin
        logic [9:0] exp_word;
        // Quiet through reset and for one cycle after it
        if (rst_d) begin
            assert (!in_ready)
                else fail_now("in_ready was high during reset or in the cycle after it");
            assert (!out_valid)
                else fail_now("out_valid was high during reset or in the cycle after it");
        end
        if (!rst) begin
            assert (!out_valid || exp_q.size() > 0)
                else fail_now("output byte seen while no reply was expected");
            if (stall_pending) begin
                assert (out_valid) else fail_now("out_valid dropped during a stall");
                assert (out_data == held_data)
                    else value_error("out_data", held_data, out_data);
                assert (out_last == held_last)
                    else value_error("out_last", 8'(held_last), 8'(out_last));
                assert (out_user == held_user)
                    else value_error("out_user", 8'(held_user), 8'(out_user));
            end
            if (out_valid && out_ready) begin
                exp_word = exp_q.pop_front();
                assert (out_data == exp_word[7:0])
                    else value_error("out_data", exp_word[7:0], out_data);
                assert (out_last == exp_word[8])
                    else value_error("out_last", 8'(exp_word[8]), 8'(out_last));
                assert (out_user == exp_word[9])
                    else value_error("out_user", 8'(exp_word[9]), 8'(out_user));
            end
        end
        stall_pending <= !rst && out_valid && !out_ready;
        rst_d         <= rst;
        held_data     <= out_data;
        held_last     <= out_last;
        held_user     <= out_user;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the replies did not all arrive in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src.f */
udp_loopback_pkg.sv
udp_hdr_parser.sv
loopback_ctrl.sv
payload_fifo.sv
udp_frame_tx.sv
udp_loopback_core.sv
tb_udp_loopback.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UDP echo engine testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module tb_udp_loopback \
    -o sim_udp_loopback

# The log decides the result, so a failing run must not stop the script here
./obj_dir/sim_udp_loopback > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
    exit 0
else
    exit 1
fi
